// File: include/obj_copy_cfg.svh
// sizes and constants of the object table copy stage
// included by the package and by every module that needs a width or a marker

`ifndef OBJ_COPY_CFG_SVH
`define OBJ_COPY_CFG_SVH

////////////////////////////////////////
// table geometry
////////////////////////////////////////

// entry counter width so a table holds 64 entries
// the ORAM address adds one bit above it for the ORAM bank
`define OBJ_AW 6

// width of one object table word
`define OBJ_DW 16

////////////////////////////////////////
// copy pacing
////////////////////////////////////////

// pixel enables given to each table entry
`define OBJ_SLOT 27

// a word with this value closes the table for the frame
`define OBJ_END_MARK 16'hFF00

`endif

// File: design/obj_pkg.sv
// types shared by the object table copy stage
// modules pull them in with a wildcard import in their header

`include "obj_copy_cfg.svh"

package obj_pkg;

    ////////////////////////////////////////
    // payload and index types
    ////////////////////////////////////////

    // one object table word as read from the SDRAM
    typedef logic [`OBJ_DW-1:0] obj_word_t;

    // entry index inside one bank of the frame buffer
    typedef logic [`OBJ_AW-1:0] obj_addr_t;

    // entry count
    // one bit wider than the index so a completely full table
    // can be reported without wrapping back to zero
    typedef logic [`OBJ_AW:0] obj_cnt_t;

endpackage

// File: design/obj_frame_seq.sv
// per frame sequencer that walks ORAM, paces entry slots on the pixel enable,
// strobes frame buffer writes and flips the frame buffer bank at line 0
`timescale 1ns/100ps

`include "obj_copy_cfg.svh"

module obj_frame_seq import obj_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic [8:0]           vdump,
    input  logic                 lvbl,
    input  logic                 obank,
    input  logic                 oram_ok,
    output logic [`OBJ_AW:0]     oram_addr,
    output obj_addr_t            wr_addr,
    output logic                 oframe_we,
    output logic                 obank_frame
);

    // slot counter only has to reach OBJ_SLOT-1
    localparam int slot_w = $clog2(`OBJ_SLOT);
    localparam logic [slot_w-1:0] slot_last = slot_w'(`OBJ_SLOT - 1);

    logic [slot_w-1:0] slot_cnt;
    obj_addr_t         entry_cnt;
    logic              done;
    logic              wtok;
    logic              line_zero;
    logic              prev_zero;
    logic              take;
    logic              oram_ok_in;

    assign oram_ok_in = oram_ok;

    ////////////////////////////////////////
    // address outputs
    ////////////////////////////////////////

    // the ORAM half picked by obank sits above the entry counter
    assign oram_addr = {obank, entry_cnt};
    assign wr_addr   = entry_cnt;

    ////////////////////////////////////////
    // frame buffer bank flag
    ////////////////////////////////////////

    assign line_zero = vdump == 9'd0;

    // toggle only on the first cycle of line 0 so a long line 0
    // still gives one flip per frame
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // start as if line 0 was already seen
            // so no flip happens straight out of reset
            prev_zero   <= 1'b1;
            obank_frame <= 1'b0;
        end else begin
            prev_zero <= line_zero;
            if (line_zero && !prev_zero) begin
                obank_frame <= ~obank_frame;
            end
        end
    end

    ////////////////////////////////////////
    // slot pacing and write strobe
    ////////////////////////////////////////

    // the token is spent on the first odd slot count that sees valid SDRAM data
    assign take = oram_ok_gate(wtok, slot_cnt[0], done);

    function automatic logic oram_ok_gate(input logic tok, input logic odd, input logic fin);
        oram_ok_gate = tok && odd && !fin;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_cnt  <= '0;
            entry_cnt <= '0;
            done      <= 1'b0;
            wtok      <= 1'b1;
            oframe_we <= 1'b0;
        end else if (!lvbl) begin
            // blanking rearms everything for the next active period
            slot_cnt  <= '0;
            entry_cnt <= '0;
            done      <= 1'b0;
            wtok      <= 1'b1;
            oframe_we <= 1'b0;
        end else begin
            // write pulse comes one cycle after the token is consumed
            oframe_we <= oram_ok_in && take;
            if (oram_ok_in && take) begin
                wtok <= 1'b0;
            end
            // pacing stops once the whole table has been walked
            if (pxl_cen && !done) begin
                if (slot_cnt == slot_last) begin
                    slot_cnt <= '0;
                    // the last count is even so rearming never races a take
                    wtok     <= 1'b1;
                    {done, entry_cnt} <= {1'b0, entry_cnt} + 1'b1;
                end else begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a write is always a single cycle strobe
    a_we_single : assert property (@(posedge clk) disable iff (rst)
        oframe_we |=> !oframe_we)
        else $error("oframe_we held high for two cycles");

    // nothing is written once blanking has been seen for a cycle
    a_we_blank : assert property (@(posedge clk) disable iff (rst)
        !lvbl |=> !oframe_we)
        else $error("oframe_we high after lvbl low");

endmodule

// File: design/obj_table_scan.sv
// scanner that captures ORAM words, stops writes after the end marker
// and reports how many entries were written in the last frame
`timescale 1ns/100ps

`include "obj_copy_cfg.svh"

module obj_table_scan import obj_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      lvbl,
    input  logic      oram_ok,
    input  obj_word_t oram_data,
    input  logic      oframe_we,
    output obj_word_t wr_data,
    output logic      wr_keep,
    output obj_cnt_t  obj_count
);

    // number of entries in a full table
    localparam obj_cnt_t table_size = obj_cnt_t'(1 << `OBJ_AW);

    obj_cnt_t run_cnt;
    logic     last_lvbl;
    logic     kept_we;

    ////////////////////////////////////////
    // word capture
    ////////////////////////////////////////

    // the sequencer spends its token in a cycle with oram_ok high
    // so this register holds that word when the write strobe arrives
    always_ff @(posedge clk) begin
        if (oram_ok) begin
            wr_data <= oram_data;
        end
    end

    ////////////////////////////////////////
    // marker and count
    ////////////////////////////////////////

    // a write only counts while the table is still open
    assign kept_we = oframe_we && wr_keep;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_cnt   <= '0;
            wr_keep   <= 1'b0;
            obj_count <= '0;
            last_lvbl <= 1'b0;
        end else begin
            last_lvbl <= lvbl;
            // the running count still holds the frame total on the
            // first blank cycle so it is copied out there
            if (last_lvbl && !lvbl) begin
                obj_count <= run_cnt;
            end
            if (!lvbl) begin
                run_cnt <= '0;
                wr_keep <= 1'b1;
            end else if (kept_we) begin
                run_cnt <= run_cnt + 1'b1;
                // the marker entry itself is written and counted
                if (wr_data == `OBJ_END_MARK) begin
                    wr_keep <= 1'b0;
                end
            end
        end
    end

    // one write per slot keeps the count within the table
    a_cnt_max : assert property (@(posedge clk) disable iff (rst)
        run_cnt <= table_size)
        else $error("entry count beyond table size");

endmodule

// File: design/obj_bank_ram.sv
// double banked frame buffer for object words
// the copy stage fills one bank while the renderer reads the other
`timescale 1ns/100ps

`include "obj_copy_cfg.svh"

module obj_bank_ram import obj_pkg::*; #(
    parameter type entry_t = obj_word_t
) (
    input  logic      clk,
    input  logic      bank,
    input  logic      we,
    input  obj_addr_t wr_addr,
    input  entry_t    wr_data,
    input  obj_addr_t rd_addr,
    output entry_t    rd_data
);

    // both banks live in one array with the bank as top address bit
    localparam int depth = 2 * (1 << `OBJ_AW);

    entry_t mem [0:depth-1];

    logic [`OBJ_AW:0] wr_idx;
    logic [`OBJ_AW:0] rd_idx;

    ////////////////////////////////////////
    // address mapping
    ////////////////////////////////////////

    // writes go to the bank being built this frame
    assign wr_idx = {bank, wr_addr};

    // reads always see the bank finished in the previous frame
    assign rd_idx = {~bank, rd_addr};

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // registered read gives data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];
    end

    // a bank flip in the same cycle as a write cannot cross the banks
    // because the flip happens at line 0 well inside blanking
    a_no_flip_write : assert property (@(posedge clk)
        (we && $changed(bank)) |-> 1'b0)
        else $error("frame buffer bank changed during a write");

endmodule

// File: design/obj_copy_top.sv
// top of the object table copy stage
// joins the sequencer, the scanner and the double banked frame buffer
`timescale 1ns/100ps

`include "obj_copy_cfg.svh"

module obj_copy_top import obj_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic [8:0]       vdump,
    input  logic             lvbl,
    input  logic             obank,
    // SDRAM side
    output logic [`OBJ_AW:0] oram_addr,
    input  logic             oram_ok,
    input  obj_word_t        oram_data,
    // renderer side
    input  obj_addr_t        rd_addr,
    output obj_word_t        rd_data,
    // status
    output logic             obank_frame,
    output obj_cnt_t         obj_count
);

    obj_addr_t wr_addr;
    obj_word_t wr_data;
    logic      oframe_we;
    logic      wr_keep;
    logic      ram_we;

    ////////////////////////////////////////
    // copy control
    ////////////////////////////////////////

    obj_frame_seq obj_frame_seq_i (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .vdump       (vdump),
        .lvbl        (lvbl),
        .obank       (obank),
        .oram_ok     (oram_ok),
        .oram_addr   (oram_addr),
        .wr_addr     (wr_addr),
        .oframe_we   (oframe_we),
        .obank_frame (obank_frame)
    );

    obj_table_scan obj_table_scan_i (
        .clk       (clk),
        .rst       (rst),
        .lvbl      (lvbl),
        .oram_ok   (oram_ok),
        .oram_data (oram_data),
        .oframe_we (oframe_we),
        .wr_data   (wr_data),
        .wr_keep   (wr_keep),
        .obj_count (obj_count)
    );

    ////////////////////////////////////////
    // frame buffer
    ////////////////////////////////////////

    // writes past the end marker are dropped here
    assign ram_we = oframe_we && wr_keep;

    obj_bank_ram #(
        .entry_t (obj_word_t)
    ) obj_bank_ram_i (
        .clk     (clk),
        .bank    (obank_frame),
        .we      (ram_we),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: verification/obj_copy_tb.sv
// self checking testbench for the object table copy stage
// plays the SDRAM and the video timing and checks counts, banks and readback
`timescale 1ns/100ps

`include "obj_copy_cfg.svh"

module obj_copy_tb import obj_pkg::*; ();

    localparam int line_len  = 256;
    localparam int tbl       = 1 << `OBJ_AW;
    // 5 short frames, one long frame and a closing blank frame
    localparam int cyc_limit = (5 * 8 + 18 + 3) * line_len + 4000;

    logic             clk;
    logic             rst;
    logic             pxl_cen;
    logic [8:0]       vdump;
    logic             lvbl;
    logic             obank;
    logic [`OBJ_AW:0] oram_addr;
    logic             oram_ok;
    obj_word_t        oram_data;
    obj_addr_t        rd_addr;
    obj_word_t        rd_data;
    logic             obank_frame;
    obj_cnt_t         obj_count;

    logic [15:0]      lfsr;
    obj_word_t        oram_mem [0:2*tbl-1];
    logic             drop_en;
    logic [`OBJ_AW:0] a_last;
    logic [`OBJ_AW:0] a_now;
    int               ok_wait;
    int               cycles;

    // frame model state, stepped on the same edges as the DUT
    obj_word_t        m_mem [0:2*tbl-1];
    logic             m_valid [0:2*tbl-1];
    int               m_slot;
    int               m_entry;
    logic             m_done;
    logic             m_tok;
    logic             m_keep;
    logic             m_bank;
    logic             m_prev_zero;
    logic             m_prev_lvbl;
    logic             m_seen;
    int               m_cnt;
    int               m_last_cnt;
    logic             pend;
    obj_word_t        pend_data;
    int               pend_addr;
    obj_addr_t        rd_q;
    logic             chk_q;

    obj_copy_top obj_copy_top_i (
        .clk         (clk),
        .rst         (rst),
        .pxl_cen     (pxl_cen),
        .vdump       (vdump),
        .lvbl        (lvbl),
        .obank       (obank),
        .oram_addr   (oram_addr),
        .oram_ok     (oram_ok),
        .oram_data   (oram_data),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .obank_frame (obank_frame),
        .obj_count   (obj_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // random source and error reporting
    ////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit handed out
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    task automatic report_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    ////////////////////////////////////////
    // frame model
    ////////////////////////////////////////

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            m_slot = 0;
            m_entry = 0;
            m_done = 0;
            m_tok = 1;
            m_keep = 0;
            m_bank = 0;
            m_prev_zero = 1;
            m_prev_lvbl = 0;
            m_seen = 0;
            m_cnt = 0;
            m_last_cnt = 0;
            pend = 0;
            for (int i = 0; i < 2 * tbl; i++) begin
                m_valid[i] = 1'b0;
            end
        end else begin
            // the strobe from the previous take lands now, with the old keep flag
            if (pend) begin
                if (m_keep) begin
                    m_mem[{m_bank, pend_addr[`OBJ_AW-1:0]}] = pend_data;
                    m_valid[{m_bank, pend_addr[`OBJ_AW-1:0]}] = 1'b1;
                    if (lvbl) begin
                        m_cnt++;
                        if (pend_data == `OBJ_END_MARK) m_keep = 1'b0;
                    end
                end
                pend = 1'b0;
            end
            if (m_prev_lvbl && !lvbl) begin
                m_last_cnt = m_cnt;
                m_seen = 1'b1;
            end
            m_prev_lvbl = lvbl;
            if ((vdump == 0) && !m_prev_zero) m_bank = ~m_bank;
            m_prev_zero = (vdump == 0);
            if (!lvbl) begin
                m_slot = 0;
                m_entry = 0;
                m_done = 0;
                m_tok = 1;
                m_cnt = 0;
                m_keep = 1;
            end else begin
                // first odd slot count with valid data takes the slot's write
                // and the word expected is the entry of the selected ORAM half
                if (oram_ok && m_tok && m_slot[0] && !m_done) begin
                    pend = 1'b1;
                    pend_data = oram_mem[{obank, obj_addr_t'(m_entry)}];
                    pend_addr = m_entry;
                    m_tok = 1'b0;
                end
                if (pxl_cen && !m_done) begin
                    if (m_slot == `OBJ_SLOT - 1) begin
                        m_slot = 0;
                        m_tok = 1'b1;
                        m_entry++;
                        if (m_entry == tbl) begin
                            m_entry = 0;
                            m_done = 1'b1;
                        end
                    end else begin
                        m_slot++;
                    end
                end
            end
            rd_q = rd_addr;
            chk_q = (vdump == 1);
        end
    end

    ////////////////////////////////////////
    // checks between the edges
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst) begin
            assert (obank_frame === m_bank)
                else report_error($sformatf("obank_frame %b, expected %b", obank_frame, m_bank));
            // the ORAM address is the selected half above the model's entry count
            assert (oram_addr === {obank, obj_addr_t'(m_entry)})
                else report_error($sformatf("oram_addr %h, expected %h",
                                           oram_addr, {obank, obj_addr_t'(m_entry)}));
            if (vdump == 1 && m_seen) begin
                assert (obj_count === obj_cnt_t'(m_last_cnt))
                    else report_error($sformatf("obj_count %0d, expected %0d",
                                               obj_count, m_last_cnt));
            end
            if (chk_q && m_valid[{~m_bank, rd_q}]) begin
                assert (rd_data === m_mem[{~m_bank, rd_q}])
                    else report_error($sformatf("rd_data %h at index %0d, expected %h",
                                               rd_data, rd_q, m_mem[{~m_bank, rd_q}]));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cyc_limit) begin
            $display("timeout: the run went past its cycle limit without finishing");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic fill_oram(input logic mark_en);
        obj_word_t v;
        int pos;
        for (int i = 0; i < 2 * tbl; i++) begin
            v = obj_word_t'(rand_bits(16));
            // only the planted marker may close the table
            if (v == `OBJ_END_MARK) v = v ^ 16'h0001;
            oram_mem[i] = v;
        end
        if (mark_en) begin
            pos = 5 + rand_bits(4);
            oram_mem[{obank, obj_addr_t'(pos)}] = `OBJ_END_MARK;
        end
    endtask

    task automatic run_frame(input int n_lines, input logic drop, input logic mark_en,
                             input logic half, input logic active);
        int tail;
        tail = 16 + rand_bits(6);
        @(posedge clk);
        #1;
        obank = half;
        drop_en = drop;
        fill_oram(mark_en);
        // the table was refilled so the SDRAM fetches the current entry again
        oram_ok = 1'b0;
        ok_wait = rand_bits(3);
        for (int ln = 0; ln < n_lines; ln++) begin
            for (int c = 0; c < line_len; c++) begin
                @(posedge clk);
                #1;
                a_now   = oram_addr;
                vdump   = 9'(ln);
                lvbl    = active && (ln >= 2) && !((ln == n_lines - 1) && (c >= line_len - tail));
                pxl_cen = ~pxl_cen;
                rd_addr = obj_addr_t'(c);
                // SDRAM answers 1 to 8 cycles after each address change
                if (a_now != a_last) begin
                    a_last  = a_now;
                    oram_ok = 1'b0;
                    ok_wait = rand_bits(3);
                end else if (!oram_ok) begin
                    if (ok_wait > 0) begin
                        ok_wait--;
                    end else if (!(drop_en && (a_last[`OBJ_AW-1:0] % 5 == 2))) begin
                        oram_ok   = 1'b1;
                        oram_data = oram_mem[a_last];
                    end
                end
            end
        end
    endtask

    initial begin
        lfsr = 16'd68;
        cycles = 0;
        rst = 1'b1;
        pxl_cen = 1'b0;
        vdump = 9'd0;
        lvbl = 1'b0;
        obank = 1'b0;
        oram_ok = 1'b0;
        oram_data = '0;
        rd_addr = '0;
        drop_en = 1'b0;
        a_last = '0;
        ok_wait = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        run_frame(8, 1'b0, 1'b0, 1'b0, 1'b1);
        run_frame(8, 1'b1, 1'b1, 1'b0, 1'b1);
        run_frame(8, 1'b0, 1'b0, 1'b1, 1'b1);
        run_frame(8, 1'b1, 1'b1, 1'b1, 1'b1);
        run_frame(8, 1'b0, 1'b0, 1'b0, 1'b1);
        // long active area walks past the table end
        run_frame(18, 1'b0, 1'b0, 1'b1, 1'b1);
        run_frame(3, 1'b0, 1'b0, 1'b1, 1'b0);

        assert (obj_count === obj_cnt_t'(tbl)) begin
            $display("TEST OK");
            $finish;
        end else begin
            report_error($sformatf("obj_count %0d after long frame, expected %0d",
                                   obj_count, tbl));
        end
    end

endmodule

// File: files.f
+incdir+include
design/obj_pkg.sv
design/obj_frame_seq.sv
design/obj_table_scan.sv
design/obj_bank_ram.sv
design/obj_copy_top.sv
verification/obj_copy_tb.sv

// File: Makefile
# Verilator build and run of the object table copy stage

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= obj_copy_tb
RTL_TOP   ?= obj_copy_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wall
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all run build lint clean

all: run

build: $(OBJ_DIR)/V$(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(FILELIST) $(wildcard design/*.sv) $(wildcard verification/*.sv) \
		$(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -Iinclude design/obj_pkg.sv design/obj_frame_seq.sv \
		design/obj_table_scan.sv design/obj_bank_ram.sv design/obj_copy_top.sv \
		--top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
